// ==== logic/fp_norm_pkg.sv ====
`default_nettype none

package fp_norm_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Wide FMA mantissa, bit 72 carries weight 2^(exp-1023)
    localparam int MANT_W = 74;

    typedef logic signed [12:0] exp_t;
    typedef logic [6:0]         lzc_t;
    typedef logic [MANT_W-1:0]  mant_t;

    // Double precision fields
    typedef logic [10:0] dbl_exp_t;
    typedef logic [51:0] frac_t;

    //////////////////////////////////////////////////////////////////////
    // Pipeline words
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
    } norm_in_t;

    // Stage 1 register, operand plus its leading-zero count
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
        lzc_t  lzc;
    } lzc_word_t;

    // Stage 2 register, leading one at the top bit
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
        logic  zero;
    } shifted_word_t;

    typedef struct packed {
        logic     sign;
        dbl_exp_t exp;
        frac_t    frac;
    } dbl_t;

endpackage

`default_nettype wire

// ==== logic/lzd_tree.sv ====
`timescale 1ns/1ns
`default_nettype none

module lzd_tree #(
    parameter int MANT_W = fp_norm_pkg::MANT_W
) (
    input  wire logic [MANT_W-1:0] mant_i,
    output fp_norm_pkg::lzc_t      lzc_o,
    output logic                   all_zero_o
);

    // Power-of-two number of 8-bit groups so the tree stays balanced
    localparam int NGRP  = 2 ** $clog2((MANT_W + 7) / 8);
    localparam int LVLS  = $clog2(NGRP);
    localparam int PAD_W = NGRP * 8;
    localparam int CW    = $clog2(PAD_W);

    // Position of the first one inside one group
    function automatic logic [2:0] base_lz(input logic [7:0] grp);
        logic [2:0] cnt;
        cnt = 3'd0;
        for (int b = 0; b < 8; b++) begin
            if (grp[b]) begin
                cnt = 3'(7 - b);
            end
        end
        return cnt;
    endfunction

    logic [PAD_W-1:0] padded;
    // Heap layout, node 0 is the root, leaves start at NGRP-1
    logic             node_z [2*NGRP-1];
    logic [CW-1:0]    node_c [2*NGRP-1];

    // Low padding is zero, never ahead of a real bit
    assign padded = PAD_W'(mant_i) << (PAD_W - MANT_W);

    //////////////////////////////////////////////////////////////////////
    // Base detectors, group 0 holds the top bits
    //////////////////////////////////////////////////////////////////////
    for (genvar g = 0; g < NGRP; g++) begin : g_base
        logic [7:0] grp;
        assign grp                = padded[PAD_W-1-8*g -: 8];
        assign node_z[NGRP-1+g]   = ~|grp;
        assign node_c[NGRP-1+g]   = CW'(base_lz(grp));
    end

    //////////////////////////////////////////////////////////////////////
    // Group combiners
    //////////////////////////////////////////////////////////////////////
    for (genvar n = 0; n < NGRP - 1; n++) begin : g_node
        localparam int DEPTH = $clog2(n + 2) - 1;
        localparam int SUB_W = 2 + LVLS - DEPTH;
        // Upper half empty, so the count continues in the lower half
        assign node_z[n] = node_z[2*n+1] & node_z[2*n+2];
        assign node_c[n] = CW'({node_z[2*n+1],
                                (node_z[2*n+1] ? node_c[2*n+2][SUB_W-1:0]
                                               : node_c[2*n+1][SUB_W-1:0])});
    end

    assign all_zero_o = node_z[0];
    assign lzc_o      = node_z[0] ? fp_norm_pkg::lzc_t'(MANT_W)
                                  : fp_norm_pkg::lzc_t'(node_c[0]);

endmodule

`default_nettype wire

// ==== logic/norm_lzc_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_lzc_stage #(
    parameter int MANT_W = fp_norm_pkg::MANT_W
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  in_req_i,
    input  wire fp_norm_pkg::norm_in_t in_data_i,
    output logic                       in_ack_o,
    output fp_norm_pkg::lzc_word_t     s1_o,
    output logic                       s1_valid_o,
    input  wire logic                  s2_ready_i
);

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_ACKED,
        IN_WAIT_RELEASE
    } in_state_t;

    in_state_t         state_q;
    fp_norm_pkg::lzc_t lzc;
    logic              load;

    lzd_tree #(
        .MANT_W (MANT_W)
    ) u_lzd (
        .mant_i     (in_data_i.mant),
        .lzc_o      (lzc),
        .all_zero_o ()
    );

    // Take a new request only when the register is empty or draining
    assign load     = (state_q == IN_IDLE) && in_req_i && (!s1_valid_o || s2_ready_i);
    assign in_ack_o = (state_q != IN_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Four-phase input handshake
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IN_IDLE;
            s1_valid_o <= 1'b0;
        end else begin
            case (state_q)
                IN_IDLE: begin
                    if (load) begin
                        state_q <= IN_ACKED;
                    end
                end
                IN_ACKED: begin
                    if (!in_req_i) begin
                        state_q <= IN_WAIT_RELEASE;
                    end
                end
                // Ack drops one clock after the request was seen low
                IN_WAIT_RELEASE: state_q <= IN_IDLE;
                default:         state_q <= IN_IDLE;
            endcase

            if (load) begin
                s1_valid_o <= 1'b1;
            end else if (s2_ready_i) begin
                s1_valid_o <= 1'b0;
            end
        end
    end

    // Operand and count registered together
    always_ff @(posedge clk_i) begin
        if (load) begin
            s1_o.sign <= in_data_i.sign;
            s1_o.exp  <= in_data_i.exp;
            s1_o.mant <= in_data_i.mant;
            s1_o.lzc  <= lzc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/norm_shift_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_shift_stage #(
    parameter int MANT_W = fp_norm_pkg::MANT_W
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire fp_norm_pkg::lzc_word_t s1_i,
    input  wire logic                   s1_valid_i,
    output logic                        s2_ready_o,
    output fp_norm_pkg::shifted_word_t  s2_o,
    output logic                        s2_valid_o,
    input  wire logic                   s3_ready_i
);

    logic [MANT_W-1:0] mant_sh;
    fp_norm_pkg::exp_t exp_adj;
    logic              is_zero;
    logic              load;

    //////////////////////////////////////////////////////////////////////
    // Normalize
    //////////////////////////////////////////////////////////////////////

    // Leading one moves to the carry-out position
    assign mant_sh = s1_i.mant << s1_i.lzc;

    // One up for the carry-out bit, then down by the shift
    assign exp_adj = s1_i.exp + fp_norm_pkg::exp_t'(1)
                   - fp_norm_pkg::exp_t'(s1_i.lzc);

    // Count of MANT_W flags an empty mantissa
    assign is_zero = (s1_i.lzc == fp_norm_pkg::lzc_t'(MANT_W));

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////
    assign s2_ready_o = !s2_valid_o || s3_ready_i;
    assign load       = s1_valid_i && s2_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s2_valid_o <= 1'b0;
        end else if (load) begin
            s2_valid_o <= 1'b1;
        end else if (s3_ready_i) begin
            s2_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            s2_o.sign <= s1_i.sign;
            s2_o.exp  <= exp_adj;
            s2_o.mant <= mant_sh;
            s2_o.zero <= is_zero;
        end
    end

endmodule

`default_nettype wire

// ==== logic/norm_round_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_round_stage (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire fp_norm_pkg::shifted_word_t s2_i,
    input  wire logic                       s2_valid_i,
    output logic                            s3_ready_o,
    output logic                            out_req_o,
    input  wire logic                       out_ack_i,
    output fp_norm_pkg::dbl_t               out_data_o
);

    // Bit positions in the normalized mantissa, hidden one at bit 73
    localparam int FRAC_HI = 72;
    localparam int FRAC_LO = 21;
    localparam int GUARD   = 20;

    typedef enum logic [1:0] {
        OUT_EMPTY,
        OUT_REQ_HIGH,
        OUT_WAIT_ACK_LOW
    } out_state_t;

    out_state_t           state_q;
    fp_norm_pkg::frac_t   frac;
    logic                 guard;
    logic                 sticky;
    logic                 round_up;
    logic [52:0]          frac_sum;
    fp_norm_pkg::exp_t    exp_r;
    fp_norm_pkg::dbl_t    result;
    logic                 load;

    //////////////////////////////////////////////////////////////////////
    // Round to nearest even
    //////////////////////////////////////////////////////////////////////
    assign frac     = s2_i.mant[FRAC_HI:FRAC_LO];
    assign guard    = s2_i.mant[GUARD];
    assign sticky   = |s2_i.mant[GUARD-1:0];
    assign round_up = guard && (sticky || frac[0]);

    // All-ones fraction wraps to zero and bumps the exponent
    assign frac_sum = {1'b0, frac} + 53'(round_up);
    assign exp_r    = s2_i.exp + fp_norm_pkg::exp_t'(frac_sum[52]);

    always_comb begin
        result.sign = s2_i.sign;
        if (s2_i.zero) begin
            result.exp  = '0;
            result.frac = '0;
        end else if (exp_r >= fp_norm_pkg::exp_t'(2047)) begin
            // Infinity
            result.exp  = '1;
            result.frac = '0;
        end else if (exp_r <= fp_norm_pkg::exp_t'(0)) begin
            // Subnormal range is flushed
            result.exp  = '0;
            result.frac = '0;
        end else begin
            result.exp  = fp_norm_pkg::dbl_exp_t'(exp_r);
            result.frac = frac_sum[51:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register and four-phase handshake
    //////////////////////////////////////////////////////////////////////

    // Free once the sink has dropped its ack
    assign s3_ready_o = (state_q == OUT_EMPTY) ||
                        ((state_q == OUT_WAIT_ACK_LOW) && !out_ack_i);
    assign load       = s3_ready_o && s2_valid_i;
    assign out_req_o  = (state_q == OUT_REQ_HIGH);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= OUT_EMPTY;
        end else begin
            case (state_q)
                OUT_EMPTY: begin
                    if (load) begin
                        state_q <= OUT_REQ_HIGH;
                    end
                end
                OUT_REQ_HIGH: begin
                    if (out_ack_i) begin
                        state_q <= OUT_WAIT_ACK_LOW;
                    end
                end
                OUT_WAIT_ACK_LOW: begin
                    if (load) begin
                        state_q <= OUT_REQ_HIGH;
                    end else if (!out_ack_i) begin
                        state_q <= OUT_EMPTY;
                    end
                end
                default: state_q <= OUT_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/norm_round_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_round_top #(
    parameter int MANT_W = fp_norm_pkg::MANT_W
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  in_req_i,
    output logic                       in_ack_o,
    input  wire fp_norm_pkg::norm_in_t in_data_i,
    output logic                       out_req_o,
    input  wire logic                  out_ack_i,
    output fp_norm_pkg::dbl_t          out_data_o
);

    fp_norm_pkg::lzc_word_t     s1;
    fp_norm_pkg::shifted_word_t s2;
    logic                       s1_valid;
    logic                       s2_valid;
    logic                       s2_ready;
    logic                       s3_ready;

    //////////////////////////////////////////////////////////////////////
    // Count, shift, round
    //////////////////////////////////////////////////////////////////////
    norm_lzc_stage #(
        .MANT_W (MANT_W)
    ) u_lzc (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_req_i   (in_req_i),
        .in_data_i  (in_data_i),
        .in_ack_o   (in_ack_o),
        .s1_o       (s1),
        .s1_valid_o (s1_valid),
        .s2_ready_i (s2_ready)
    );

    norm_shift_stage #(
        .MANT_W (MANT_W)
    ) u_shift (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .s1_i       (s1),
        .s1_valid_i (s1_valid),
        .s2_ready_o (s2_ready),
        .s2_o       (s2),
        .s2_valid_o (s2_valid),
        .s3_ready_i (s3_ready)
    );

    norm_round_stage u_round (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .s2_i       (s2),
        .s2_valid_i (s2_valid),
        .s3_ready_o (s3_ready),
        .out_req_o  (out_req_o),
        .out_ack_i  (out_ack_i),
        .out_data_o (out_data_o)
    );

endmodule

`default_nettype wire

// ==== verification/norm_round_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_round_assertions (
    input wire logic                  clk_i,
    input wire logic                  rst_n_i,
    input wire logic                  in_req_i,
    input wire logic                  in_ack_o,
    input wire fp_norm_pkg::norm_in_t in_data_i,
    input wire logic                  out_req_o,
    input wire logic                  out_ack_i,
    input wire fp_norm_pkg::dbl_t     out_data_o
);

    int fail_cnt = 0;

    // Source keeps its request up until the ack arrives
    in_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_req_i && !in_ack_o |=> in_req_i)
        else begin
            $error("in_req_i dropped before in_ack_o rose");
            fail_cnt++;
        end

    in_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_req_i && !in_ack_o |=> $stable(in_data_i))
        else begin
            $error("in_data_i changed during an open request");
            fail_cnt++;
        end

    // Output request waits for the sink
    out_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_req_o && !out_ack_i |=> out_req_o)
        else begin
            $error("out_req_o dropped before out_ack_i rose");
            fail_cnt++;
        end

    out_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_req_o |=> $stable(out_data_o))
        else begin
            $error("out_data_o changed while out_req_o was high");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !in_ack_o && !out_req_o)
        else begin
            $error("handshake outputs high right after reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== verification/norm_round_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module norm_round_tb;

    localparam int NUM_OPS     = 2000;
    localparam int CLK_HALF    = 50;
    localparam int WATCHDOG_NS = NUM_OPS * 20 * 100;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  in_req_i;
    logic                  in_ack_o;
    fp_norm_pkg::norm_in_t in_data_i;
    logic                  out_req_o;
    logic                  out_ack_i;
    fp_norm_pkg::dbl_t     out_data_o;

    fp_norm_pkg::dbl_t expected_q[$];
    int                error_cnt;
    int                sent_cnt;
    int                recv_cnt;
    longint            cycle_cnt;
    longint            first_ack_cycle;
    longint            first_req_cycle;

    norm_round_top dut0 (.*);

    bind norm_round_top norm_round_assertions u_assert (.*);

    initial clk_i = 1'b0;
    always #CLK_HALF clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic fp_norm_pkg::dbl_t expected_double(input fp_norm_pkg::norm_in_t op);
        fp_norm_pkg::dbl_t res;
        logic [73:0]       norm;
        logic [52:0]       rounded;
        int                lead;
        int                biased;
        res      = '0;
        res.sign = op.sign;
        lead     = -1;
        for (int b = 0; b < 74; b++) begin
            if (op.mant[b]) begin
                lead = b;
            end
        end
        // Empty mantissa keeps only the sign
        if (lead < 0) begin
            return res;
        end
        norm    = op.mant << (73 - lead);
        biased  = int'($signed(op.exp)) + lead - 72;
        rounded = {1'b0, norm[72:21]};
        if (norm[20] && ((|norm[19:0]) || norm[21])) begin
            rounded = rounded + 53'd1;
        end
        if (rounded[52]) begin
            biased = biased + 1;
        end
        if (biased >= 2047) begin
            res.exp = '1;
        end else if (biased > 0) begin
            res.exp  = 11'(biased);
            res.frac = rounded[51:0];
        end
        return res;
    endfunction

    // Kinds 0..6 stress one corner each and the rest are general
    function automatic fp_norm_pkg::norm_in_t random_operand(input int kind);
        fp_norm_pkg::norm_in_t op;
        logic [73:0]           low;
        int                    lead;
        int                    target;
        low    = 74'({$urandom, $urandom, $urandom});
        lead   = $urandom_range(73, 0);
        target = $urandom_range(2040, 8);
        case (kind)
            0: lead = 73;
            1: lead = $urandom_range(15, 0);
            2: begin
                // Fraction and guard all ones so rounding ripples into the exponent
                lead = $urandom_range(73, 53);
                low  = low | ((74'd1 << lead) - (74'd1 << (lead - 53)));
            end
            3: begin
                // Exact tie with the guard set and nothing below it
                lead = $urandom_range(73, 53);
                low  = low & ~((74'd1 << (lead - 53)) - 74'd1);
                low[lead-53] = 1'b1;
            end
            5: target = int'($urandom_range(4, 0)) - 2;
            6: target = 2044 + int'($urandom_range(4, 0));
            default: ;
        endcase
        op.sign = 1'($urandom_range(1, 0));
        op.mant = (low & ((74'd1 << lead) - 74'd1)) | (74'd1 << lead);
        op.exp  = fp_norm_pkg::exp_t'(target + 72 - lead);
        if (kind == 4) begin
            op.mant = '0;
        end
        return op;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Source, sink and monitors
    //////////////////////////////////////////////////////////////////////
    task automatic send_operand(input fp_norm_pkg::norm_in_t op);
        in_data_i <= op;
        in_req_i  <= 1'b1;
        expected_q.push_back(expected_double(op));
        sent_cnt++;
        do @(posedge clk_i); while (!in_ack_o);
        in_req_i <= 1'b0;
        do @(posedge clk_i); while (in_ack_o);
    endtask

    initial begin : sink
        fp_norm_pkg::dbl_t exp_val;
        forever begin
            @(posedge clk_i);
            if (out_req_o) begin
                recv_cnt++;
                if (expected_q.size() == 0) begin
                    $display("result %h arrived with no operand outstanding", out_data_o);
                    error_cnt++;
                end else begin
                    exp_val = expected_q.pop_front();
                    if (out_data_o !== exp_val) begin
                        $display("mismatch out_data_o expected %h actual %h",
                                 exp_val, out_data_o);
                        error_cnt++;
                    end
                end
                repeat ($urandom_range(5, 0)) @(posedge clk_i);
                out_ack_i <= 1'b1;
                do @(posedge clk_i); while (out_req_o);
                out_ack_i <= 1'b0;
            end
        end
    end

    // First ack and first output request give the empty-pipe latency
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (in_ack_o && first_ack_cycle < 0) begin
            first_ack_cycle = cycle_cnt;
        end
        if (out_req_o && first_req_cycle < 0) begin
            first_req_cycle = cycle_cnt;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int total;
        void'($urandom(32'h83c4));
        rst_n_i         = 1'b0;
        in_req_i        = 1'b0;
        in_data_i       = '0;
        out_ack_i       = 1'b0;
        error_cnt       = 0;
        sent_cnt        = 0;
        recv_cnt        = 0;
        cycle_cnt       = 0;
        first_ack_cycle = -1;
        first_req_cycle = -1;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            send_operand(random_operand($urandom_range(9, 0)));
        end
        while (recv_cnt < sent_cnt) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);

        if (recv_cnt != sent_cnt || expected_q.size() != 0) begin
            $display("sent %0d operands but received %0d results, %0d still queued",
                     sent_cnt, recv_cnt, expected_q.size());
            error_cnt++;
        end
        if (first_req_cycle - first_ack_cycle != 2) begin
            $display("mismatch out_req_o latency expected %0h actual %0h",
                     2, first_req_cycle - first_ack_cycle);
            error_cnt++;
        end
        total = error_cnt + dut0.u_assert.fail_cnt;
        $display("errors: %0d (checks %0d, assertions %0d, results %0d)",
                 total, error_cnt, dut0.u_assert.fail_cnt, recv_cnt);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== norm_round_top.f ====
logic/fp_norm_pkg.sv
logic/lzd_tree.sv
logic/norm_lzc_stage.sv
logic/norm_shift_stage.sv
logic/norm_round_stage.sv
logic/norm_round_top.sv
verification/norm_round_assertions.sv
verification/norm_round_tb.sv
